// File: int_issue_pkg.sv
package int_issue_pkg;

    localparam int PREG_W = 5;
    localparam int ROB_W  = 4;  // Index bits, the wrap direction bit comes on top.
    localparam int DATA_W = 32;
    localparam int DISP_W = 2;
    localparam int WB_W   = 2;

    typedef struct packed {
        logic             dir;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JAL,
        BR_JALR
    } branch_op_t;

    typedef struct packed {
        logic [PREG_W-1:0] rs1;
        logic [PREG_W-1:0] rs2;
        logic [PREG_W-1:0] rd;
        rob_idx_t          rob;
        branch_op_t        bop;
        logic [15:0]       imm;
    } uop_t;

    typedef struct packed {
        logic valid;
        uop_t uop;
        logic rs1_ready;
        logic rs2_ready;
    } disp_slot_t;

    typedef struct packed {
        logic              valid;
        logic [PREG_W-1:0] rd;
        logic [DATA_W-1:0] data;
    } wb_port_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob;
    } redirect_t;

    typedef enum logic [1:0] {
        CONDITION,
        DIRECT,
        INDIRECT,
        CALL
    } br_type_t;

    typedef enum logic [1:0] {
        RAS_NONE,
        RAS_POP,
        RAS_PUSH,
        RAS_POP_PUSH
    } ras_type_t;

    typedef struct packed {
        logic              valid;
        uop_t              uop;
        logic [DATA_W-1:0] rs1_data;
        logic [DATA_W-1:0] rs2_data;
        br_type_t          br_type;
        ras_type_t         ras_type;
    } issue_t;

    // True when a is younger than b.
    function automatic logic rob_younger(input rob_idx_t a, input rob_idx_t b);
        return (a.dir ^ b.dir) ^ (a.idx < b.idx);
    endfunction

endpackage

// File: issue_bank.sv
`timescale 1ns/1ps

module issue_bank #(
    parameter int BANK_DEPTH = 4
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n_i,
    input  int_issue_pkg::disp_slot_t [int_issue_pkg::DISP_W-1:0] wr_i,
    input  int_issue_pkg::wb_port_t [int_issue_pkg::WB_W-1:0]     wb_i,
    input  int_issue_pkg::redirect_t                              redirect_i,
    output int_issue_pkg::uop_t                                   sel_o,
    output logic                                                  sel_valid_o,
    output logic [$clog2(BANK_DEPTH+1)-1:0]                       free_o,
    output logic [$clog2(BANK_DEPTH+1)-1:0]                       credit_o
);
    import int_issue_pkg::*;

    localparam int CNT_W = $clog2(BANK_DEPTH + 1);
    localparam int IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    logic [BANK_DEPTH-1:0] valid_q, valid_d;
    logic [BANK_DEPTH-1:0] rs1_rdy_q, rs2_rdy_q;
    uop_t                  uop_q [BANK_DEPTH];
    logic [BANK_DEPTH-1:0] ready, kill;
    logic [IDX_W-1:0]      first_free, second_free, sel_idx;
    logic [IDX_W-1:0]      wr_idx [DISP_W];
    logic [DISP_W-1:0]     wr_en, wr_drop;
    logic                  any_ready;
    logic [CNT_W-1:0]      free_cnt, credit_d, credit_q;

    function automatic logic wb_hit(input wb_port_t [WB_W-1:0] wb,
                                    input logic [PREG_W-1:0] tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WB_W; p++) begin
            hit |= wb[p].valid && (wb[p].rd == tag);
        end
        return hit;
    endfunction

    // Free entry search, the two lowest indices.
    always_comb begin
        int n_found;
        n_found     = 0;
        free_cnt    = '0;
        first_free  = '0;
        second_free = '0;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            if (!valid_q[i]) begin
                free_cnt = free_cnt + 1'b1;
                if (n_found == 0) first_free = IDX_W'(i);
                else if (n_found == 1) second_free = IDX_W'(i);
                n_found++;
            end
        end
    end

    always_comb begin
        wr_idx[0] = first_free;
        wr_idx[1] = wr_i[0].valid ? second_free : first_free;
        for (int s = 0; s < DISP_W; s++) begin
            wr_drop[s] = wr_i[s].valid && redirect_i.valid &&
                         rob_younger(wr_i[s].uop.rob, redirect_i.rob);  // Flushed on arrival.
            wr_en[s]   = wr_i[s].valid && !wr_drop[s];
        end
    end

    // Lowest ready index wins.
    always_comb begin
        sel_idx   = '0;
        any_ready = 1'b0;
        for (int i = BANK_DEPTH - 1; i >= 0; i--) begin
            ready[i] = valid_q[i] && rs1_rdy_q[i] && rs2_rdy_q[i];
            if (ready[i]) begin
                sel_idx   = IDX_W'(i);
                any_ready = 1'b1;
            end
        end
    end

    assign sel_valid_o = any_ready && !redirect_i.valid;
    assign sel_o       = uop_q[sel_idx];

    always_comb begin
        for (int i = 0; i < BANK_DEPTH; i++) begin
            kill[i] = redirect_i.valid && valid_q[i] && rob_younger(uop_q[i].rob, redirect_i.rob);
        end
        valid_d = valid_q & ~kill;
        if (sel_valid_o) valid_d[sel_idx] = 1'b0;
        for (int s = 0; s < DISP_W; s++) begin
            if (wr_en[s]) valid_d[wr_idx[s]] = 1'b1;
        end
        credit_d = CNT_W'(sel_valid_o);
        for (int i = 0; i < BANK_DEPTH; i++) begin
            credit_d = credit_d + CNT_W'(kill[i]);
        end
        for (int s = 0; s < DISP_W; s++) begin
            credit_d = credit_d + CNT_W'(wr_drop[s]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= '0;
            credit_q <= '0;
        end else begin
            valid_q  <= valid_d;
            credit_q <= credit_d;
        end
    end

    // Payload and wakeup, qualified by valid_q.
    always_ff @(posedge clk) begin
        for (int i = 0; i < BANK_DEPTH; i++) begin
            rs1_rdy_q[i] <= rs1_rdy_q[i] | wb_hit(wb_i, uop_q[i].rs1);
            rs2_rdy_q[i] <= rs2_rdy_q[i] | wb_hit(wb_i, uop_q[i].rs2);
        end
        for (int s = 0; s < DISP_W; s++) begin
            if (wr_en[s]) begin
                uop_q[wr_idx[s]]     <= wr_i[s].uop;
                rs1_rdy_q[wr_idx[s]] <= wr_i[s].rs1_ready | wb_hit(wb_i, wr_i[s].uop.rs1);
                rs2_rdy_q[wr_idx[s]] <= wr_i[s].rs2_ready | wb_hit(wb_i, wr_i[s].uop.rs2);
            end
        end
    end

    assign free_o   = free_cnt;
    assign credit_o = credit_q;

endmodule

// File: bank_steer.sv
`timescale 1ns/1ps

module bank_steer #(
    parameter int BANKS      = 2,
    parameter int BANK_DEPTH = 4
) (
    input  int_issue_pkg::disp_slot_t [int_issue_pkg::DISP_W-1:0]            disp_i,
    input  logic [BANKS-1:0][$clog2(BANK_DEPTH+1)-1:0]                        free_i,
    output int_issue_pkg::disp_slot_t [BANKS-1:0][int_issue_pkg::DISP_W-1:0] wr_o
);
    import int_issue_pkg::*;

    localparam int CNT_W = $clog2(BANK_DEPTH + 1);

    logic [BANKS-1:0][CNT_W-1:0] free_adj;
    int                          pick0, pick1;

    always_comb begin
        pick0 = 0;
        for (int b = 1; b < BANKS; b++) begin
            if (free_i[b] > free_i[pick0]) pick0 = b;  // Strict compare keeps the lower bank on ties.
        end

        free_adj = free_i;
        if (disp_i[0].valid && free_adj[pick0] != '0) begin
            free_adj[pick0] = free_adj[pick0] - 1'b1;
        end

        pick1 = 0;
        for (int b = 1; b < BANKS; b++) begin
            if (free_adj[b] > free_adj[pick1]) pick1 = b;
        end

        wr_o = '0;
        wr_o[pick0][0] = disp_i[0];
        wr_o[pick1][1] = disp_i[1];
    end

endmodule

// File: issue_regread.sv
`timescale 1ns/1ps

module issue_regread #(
    parameter int BANKS     = 2,
    parameter int NUM_PREGS = 32
) (
    input  logic                                              clk,
    input  logic                                              rst_n_i,
    input  int_issue_pkg::uop_t [BANKS-1:0]                   sel_i,
    input  logic [BANKS-1:0]                                  sel_valid_i,
    input  int_issue_pkg::wb_port_t [int_issue_pkg::WB_W-1:0] wb_i,
    input  int_issue_pkg::redirect_t                          redirect_i,
    output int_issue_pkg::issue_t [BANKS-1:0]                 issue_o
);
    import int_issue_pkg::*;

    logic [DATA_W-1:0] rf_q [NUM_PREGS];
    issue_t [BANKS-1:0] issue_d, issue_q;

    // Link registers x1 and x5 drive the return stack.
    function automatic ras_type_t ras_class(input uop_t u);
        logic push, pop;
        push = (u.rd == 5'd1) || (u.rd == 5'd5);
        pop  = (u.rs1 == 5'd1) || (u.rs1 == 5'd5);
        case ({push, pop})
            2'b01:   return RAS_POP;
            2'b10:   return RAS_PUSH;
            2'b11:   return RAS_POP_PUSH;
            default: return RAS_NONE;
        endcase
    endfunction

    function automatic br_type_t br_class(input uop_t u, input ras_type_t ras);
        if (u.bop == BR_JAL) return DIRECT;
        if (u.bop == BR_JALR) return (ras != RAS_NONE) ? CALL : INDIRECT;
        return CONDITION;
    endfunction

    always_ff @(posedge clk) begin
        for (int p = 0; p < WB_W; p++) begin
            if (wb_i[p].valid) rf_q[wb_i[p].rd] <= wb_i[p].data;
        end
    end

    always_comb begin
        for (int l = 0; l < BANKS; l++) begin
            issue_d[l].valid    = sel_valid_i[l] &&
                                  !(redirect_i.valid && rob_younger(sel_i[l].rob, redirect_i.rob));
            issue_d[l].uop      = sel_i[l];
            issue_d[l].rs1_data = (sel_i[l].rs1 == '0) ? '0 : rf_q[sel_i[l].rs1];  // x0 is zero.
            issue_d[l].rs2_data = (sel_i[l].rs2 == '0) ? '0 : rf_q[sel_i[l].rs2];
            issue_d[l].ras_type = ras_class(sel_i[l]);
            issue_d[l].br_type  = br_class(sel_i[l], issue_d[l].ras_type);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            issue_q <= '0;
        end else begin
            issue_q <= issue_d;
        end
    end

    assign issue_o = issue_q;

endmodule

// File: int_issue_queue.sv
`timescale 1ns/1ps

module int_issue_queue #(
    parameter int BANKS      = 2,
    parameter int BANK_DEPTH = 4,
    parameter int NUM_PREGS  = 32
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n_i,
    input  int_issue_pkg::disp_slot_t [int_issue_pkg::DISP_W-1:0] disp_i,
    input  int_issue_pkg::wb_port_t [int_issue_pkg::WB_W-1:0]     wb_i,
    input  int_issue_pkg::redirect_t                              redirect_i,
    output int_issue_pkg::issue_t [BANKS-1:0]                     issue_o,
    output logic [$clog2(BANKS*BANK_DEPTH+1)-1:0]                 credit_o
);
    import int_issue_pkg::*;

    localparam int CNT_W  = $clog2(BANK_DEPTH + 1);
    localparam int CRED_W = $clog2(BANKS * BANK_DEPTH + 1);

    disp_slot_t [BANKS-1:0][DISP_W-1:0] bank_wr;
    uop_t [BANKS-1:0]                   sel_uop;
    logic [BANKS-1:0]                   sel_valid;
    logic [BANKS-1:0][CNT_W-1:0]        bank_free;
    logic [BANKS-1:0][CNT_W-1:0]        bank_credit;

    bank_steer #(
        .BANKS      (BANKS),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_steer (
        .disp_i (disp_i),
        .free_i (bank_free),
        .wr_o   (bank_wr)
    );

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        issue_bank #(
            .BANK_DEPTH (BANK_DEPTH)
        ) u_bank (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .wr_i        (bank_wr[b]),
            .wb_i        (wb_i),
            .redirect_i  (redirect_i),
            .sel_o       (sel_uop[b]),
            .sel_valid_o (sel_valid[b]),
            .free_o      (bank_free[b]),
            .credit_o    (bank_credit[b])
        );
    end

    issue_regread #(
        .BANKS     (BANKS),
        .NUM_PREGS (NUM_PREGS)
    ) u_regread (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .sel_i       (sel_uop),
        .sel_valid_i (sel_valid),
        .wb_i        (wb_i),
        .redirect_i  (redirect_i),
        .issue_o     (issue_o)
    );

    // Credits returned by all banks this cycle.
    always_comb begin
        credit_o = '0;
        for (int b = 0; b < BANKS; b++) begin
            credit_o = credit_o + CRED_W'(bank_credit[b]);
        end
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// File: int_issue_queue_properties.sv
`timescale 1ns/1ps

module int_issue_queue_properties #(
    parameter int BANKS      = 2,
    parameter int BANK_DEPTH = 4
) (
    input logic                                   clk,
    input logic                                   rst_n_i,
    input int_issue_pkg::issue_t [BANKS-1:0]      issue_o,
    input logic [$clog2(BANKS*BANK_DEPTH+1)-1:0] credit_o
);
    import int_issue_pkg::*;

    logic [BANKS-1:0] lane_valid;

    always_comb begin
        for (int l = 0; l < BANKS; l++) lane_valid[l] = issue_o[l].valid;
    end

    a_credit_in_reset: assert property (@(posedge clk) !rst_n_i |-> credit_o == '0)
        else $error("credit_o is nonzero while reset is asserted");

    a_idle_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |=> lane_valid == '0)
        else $error("an issue lane is valid in the cycle after reset");

    a_credit_cap: assert property (@(posedge clk) disable iff (!rst_n_i)
        int'(credit_o) <= BANKS * BANK_DEPTH)
        else $error("credit_o returns more than the queue capacity");

endmodule

bind int_issue_queue int_issue_queue_properties #(
    .BANKS      (BANKS),
    .BANK_DEPTH (BANK_DEPTH)
) u_props (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .issue_o  (issue_o),
    .credit_o (credit_o)
);

// File: tb_int_issue_queue.sv
`timescale 1ns/1ps

module tb_int_issue_queue;
    import int_issue_pkg::*;

    localparam int BANKS = 2;
    localparam int BANK_DEPTH = 4;
    localparam int CAPACITY = BANKS * BANK_DEPTH;
    localparam int PERIOD = 20;

    logic clk, rst_n_i;
    disp_slot_t [DISP_W-1:0] disp_i;
    wb_port_t [WB_W-1:0] wb_i;
    redirect_t redirect_i;
    issue_t [BANKS-1:0] issue_o;
    logic [$clog2(CAPACITY+1)-1:0] credit_o;

    logic [DATA_W-1:0] model_rf [32];
    logic [31:0] sb_valid, sb_r1, sb_r2;  // Scoreboard keyed by ROB index.
    uop_t sb_uop [32];
    int credits = CAPACITY, credit_sum = 0, dispatched = 0, trace_len = 0;
    logic [31:0] lcg_state = 32'd84;

    tb_clock_gen #(.PERIOD_NS(PERIOD)) u_clk (.clk_o(clk));

    int_issue_queue #(.BANKS(BANKS), .BANK_DEPTH(BANK_DEPTH), .NUM_PREGS(32)) uut (
        .clk(clk), .rst_n_i(rst_n_i), .disp_i(disp_i), .wb_i(wb_i),
        .redirect_i(redirect_i), .issue_o(issue_o), .credit_o(credit_o)
    );

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Age order flips when the wrap directions differ.
    function automatic logic is_younger(input rob_idx_t a, input rob_idx_t b);
        if (a.dir == b.dir) return a.idx < b.idx;
        return a.idx >= b.idx;
    endfunction

    function automatic issue_t expected_issue(input uop_t u);
        issue_t e;
        logic push, pop;
        e = '0;
        e.valid = 1'b1;
        e.uop = u;
        e.rs1_data = (u.rs1 == 0) ? '0 : model_rf[u.rs1];
        e.rs2_data = (u.rs2 == 0) ? '0 : model_rf[u.rs2];
        push = (u.rd == 1) || (u.rd == 5);
        pop = (u.rs1 == 1) || (u.rs1 == 5);
        e.ras_type = (push && pop) ? RAS_POP_PUSH : push ? RAS_PUSH : pop ? RAS_POP : RAS_NONE;
        if (u.bop == BR_JAL) e.br_type = DIRECT;
        else if (u.bop == BR_JALR) e.br_type = (push || pop) ? CALL : INDIRECT;
        else e.br_type = CONDITION;
        return e;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "stopped");
    endtask

    task automatic check_issue(input string name, input issue_t exp, input issue_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            stop_run("issue bundle mismatch");
        end
    endtask

    task automatic check_credit(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            stop_run("credit count mismatch");
        end
    endtask

    // Outputs of the last edge are checked, then last cycle's writebacks enter the model.
    task automatic sample_cycle();
        rob_idx_t r;
        @(negedge clk);
        for (int l = 0; l < BANKS; l++) begin
            if (issue_o[l].valid) begin
                r = issue_o[l].uop.rob;
                if (!sb_valid[r]) stop_run($sformatf("lane %0d issued unexpected ROB %h", l, r));
                if (!(sb_r1[r] && sb_r2[r])) stop_run($sformatf("ROB %h issued early", r));
                check_issue($sformatf("issue rob %h", r), expected_issue(sb_uop[r]), issue_o[l]);
                sb_valid[r] = 1'b0;
            end
        end
        credits += int'(credit_o);
        credit_sum += int'(credit_o);
        for (int p = 0; p < WB_W; p++) begin
            if (wb_i[p].valid) begin
                model_rf[wb_i[p].rd] = wb_i[p].data;
                for (int i = 0; i < 32; i++) begin
                    if (sb_uop[i].rs1 == wb_i[p].rd) sb_r1[i] = 1'b1;
                    if (sb_uop[i].rs2 == wb_i[p].rd) sb_r2[i] = 1'b1;
                end
            end
        end
        disp_i = '0;
        wb_i = '0;
        redirect_i = '0;
    endtask

    task automatic run_line(input string line);
        int f [16];
        int n, b;
        disp_slot_t sl;
        sample_cycle();
        case (line[0])
            "D": begin
                n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                            f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                if (n != 16) stop_run("malformed dispatch line in the trace");
                for (int s = 0; s < DISP_W; s++) begin
                    b = s * 8;
                    sl = '0;
                    sl.valid = f[b] != 0;
                    sl.uop.rs1 = PREG_W'(f[b+1]);
                    sl.uop.rs2 = PREG_W'(f[b+2]);
                    sl.uop.rd = PREG_W'(f[b+3]);
                    sl.uop.rob = 5'(f[b+4]);
                    sl.uop.bop = branch_op_t'(2'(f[b+5]));
                    sl.uop.imm = next_rand();
                    sl.rs1_ready = f[b+6] != 0;
                    sl.rs2_ready = f[b+7] != 0;
                    if (sl.valid) begin
                        if (credits == 0) stop_run("dispatch without a free credit");
                        if (sb_valid[sl.uop.rob]) stop_run("ROB index dispatched twice");
                        credits--;
                        dispatched++;
                        sb_valid[sl.uop.rob] = 1'b1;
                        sb_uop[sl.uop.rob] = sl.uop;
                        sb_r1[sl.uop.rob] = sl.rs1_ready;
                        sb_r2[sl.uop.rob] = sl.rs2_ready;
                    end
                    disp_i[s] = sl;
                end
            end
            "W": begin
                n = $sscanf(line, "W %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
                if (n != 6) stop_run("malformed writeback line in the trace");
                for (int p = 0; p < WB_W; p++) begin
                    wb_i[p].valid = f[p*3] != 0;
                    wb_i[p].rd = PREG_W'(f[p*3+1]);
                    wb_i[p].data = DATA_W'(f[p*3+2]);
                end
            end
            "R": begin
                n = $sscanf(line, "R %h", f[0]);
                if (n != 1) stop_run("malformed redirect line in the trace");
                redirect_i.valid = 1'b1;
                redirect_i.rob = 5'(f[0]);
                for (int i = 0; i < 32; i++) begin
                    if (sb_valid[i] && is_younger(sb_uop[i].rob, redirect_i.rob)) sb_valid[i] = 1'b0;
                end
            end
            "I": begin
                n = $sscanf(line, "I %d", f[0]);
                if (n != 1) stop_run("malformed idle line in the trace");
                repeat (f[0]) sample_cycle();
            end
            "E": begin
                if (sb_valid != '0) stop_run("micro-ops still waiting at the end of the trace");
                check_credit("final credits", CAPACITY, credits);
                check_credit("credit total", dispatched, credit_sum);
            end
            default: stop_run($sformatf("unknown trace command %s", line));
        endcase
    endtask

    initial begin
        wait (trace_len > 0);
        #(trace_len * 20 * PERIOD);
        $display("Watchdog expired before the trace finished");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    initial begin
        string lines [$];
        string line;
        int fd;
        rst_n_i = 1'b0;
        disp_i = '0;
        wb_i = '0;
        redirect_i = '0;
        sb_valid = '0;
        sb_r1 = '0;
        sb_r2 = '0;
        for (int i = 0; i < 32; i++) sb_uop[i] = '0;
        fd = $fopen("issue_trace.txt", "r");
        if (fd == 0) stop_run("cannot open issue_trace.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") lines.push_back(line);
        end
        $fclose(fd);
        trace_len = lines.size();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        foreach (lines[i]) run_line(lines[i]);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: int_issue_queue.f
int_issue_pkg.sv
issue_bank.sv
bank_steer.sv
issue_regread.sv
int_issue_queue.sv
tb_clock_gen.sv
int_issue_queue_properties.sv
tb_int_issue_queue.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_int_issue_queue -f int_issue_queue.f
./obj_dir/Vtb_int_issue_queue

// File: issue_trace.txt
# D: per slot valid rs1 rs2 rd rob bop rdy1 rdy2 | W: per port valid rd data
# R: redirect rob (bit 4 is the wrap direction) | I: idle cycles | E: final checks
W 1 01 11111111 1 02 22222222
W 1 03 33333333 1 05 55555555
W 1 06 66666666 1 07 77777777
D 1 01 02 08 00 0 1 1 1 00 03 09 01 1 1 1
D 1 02 03 01 02 2 1 1 1 06 00 00 03 3 1 1
D 1 01 00 05 04 3 1 1 1 05 00 00 05 3 1 1
I 3
D 1 0a 01 0b 06 0 0 1 1 0b 02 0c 07 1 0 1
I 2
W 1 0a aaaaaaaa 0 00 0
I 2
W 1 0b bbbbbbbb 0 00 0
I 3
D 1 0c 00 0d 09 0 0 1 1 0c 00 0d 18 0 0 1
D 1 0c 00 0d 1b 1 0 1 1 0c 00 0d 0a 0 0 1
R 08
W 1 0c cccccccc 0 00 0
I 6
D 1 10 00 14 0b 0 0 1 1 11 00 14 0c 0 0 1
D 1 10 00 14 0d 0 0 1 1 10 00 14 0e 0 0 1
D 1 12 00 14 0f 0 0 1 1 10 00 14 10 0 0 1
D 1 13 00 14 11 0 0 1 1 13 00 14 12 0 0 1
W 1 10 10101010 0 00 0
I 6
W 1 11 11110000 1 12 12121212
W 1 13 13131313 0 00 0
I 8
E
